// ==== hw/plot_params.svh ====
`ifndef PLOT_PARAMS_SVH
`define PLOT_PARAMS_SVH

// Signed coordinate width, shared by position, center and end point
`define PLOT_POS_BITS 12

// Unsigned squared distance, wide enough for the sum of two squares
`define PLOT_R2_BITS (2 * `PLOT_POS_BITS + 2)

// One root bit per pair of squared radius bits
`define PLOT_R_BITS (`PLOT_R2_BITS / 2)

// Step cap is factor * radius + factor
`define PLOT_CAP_FACTOR 8

`endif

// ==== hw/plot_pkg.sv ====
`include "plot_params.svh"

package plot_pkg;

	typedef logic signed [`PLOT_POS_BITS-1:0] pos_t;
	typedef logic [`PLOT_R2_BITS-1:0] r2_t;
	typedef logic [`PLOT_R_BITS-1:0] root_t;

	typedef enum logic [2:0] {
		OP_MOVE = 3'd0,
		OP_PEN_UP = 3'd1,
		OP_PEN_DOWN = 3'd2,
		OP_ARC_CW = 3'd3,
		OP_ARC_CCW = 3'd4
	} opcode_t;

	typedef enum logic [1:0] {Q1, Q2, Q3, Q4} quadrant_t;

	// Counter-clockwise order starting on the positive x axis
	typedef enum logic [2:0] {E, NE, N, NW, W, SW, S, SE} step_dir_t;

	typedef enum logic [2:0] {ARC_IDLE, ARC_SQRT, ARC_STEP, ARC_END} arc_state_t;

	function automatic logic signed [1:0] dir_dx(step_dir_t dir);
		case (dir)
			E, NE, SE: return 2'sb01;
			W, NW, SW: return 2'sb11;
			default: return 2'sb00;
		endcase
	endfunction

	function automatic logic signed [1:0] dir_dy(step_dir_t dir);
		case (dir)
			N, NE, NW: return 2'sb01;
			S, SE, SW: return 2'sb11;
			default: return 2'sb00;
		endcase
	endfunction

endpackage

// ==== hw/int_sqrt.sv ====
`timescale 1ns/1ps
`include "plot_params.svh"

module int_sqrt (
	input logic clk,
	input logic reset,
	input logic sqrt_start,
	input plot_pkg::r2_t sqrt_in,
	output logic sqrt_done,
	output plot_pkg::root_t sqrt_out
);

	localparam int ROOT_BITS = `PLOT_R_BITS;
	localparam int REM_BITS = `PLOT_R_BITS + 2;
	localparam int CNT_BITS = $clog2(ROOT_BITS);
	localparam logic [CNT_BITS-1:0] CNT_LOAD = CNT_BITS'(ROOT_BITS - 1);

	plot_pkg::r2_t rad;
	logic [REM_BITS-1:0] rem;
	plot_pkg::root_t root;
	logic busy;
	logic [CNT_BITS-1:0] cnt;

	plot_pkg::r2_t src_rad;
	logic [REM_BITS-1:0] src_rem;
	plot_pkg::root_t src_root;
	logic [REM_BITS-1:0] shifted;
	logic [REM_BITS-1:0] trial;
	logic fits;

	// The start cycle already resolves the top bit pair
	always_comb begin
		src_rad = sqrt_start ? sqrt_in : rad;
		src_rem = sqrt_start ? '0 : rem;
		src_root = sqrt_start ? '0 : root;
		shifted = {src_rem[REM_BITS-3:0], src_rad[`PLOT_R2_BITS-1 -: 2]};
		trial = {src_root, 2'b01};
		fits = shifted >= trial;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt <= '0;
			sqrt_done <= 1'b0;
		end else begin
			sqrt_done <= 1'b0;
			if (sqrt_start) begin
				busy <= 1'b1; // A start while busy restarts the root
				cnt <= CNT_LOAD;
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				if (cnt == CNT_BITS'(1)) begin
					busy <= 1'b0;
					sqrt_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sqrt_start || busy) begin
			rad <= src_rad << 2;
			rem <= fits ? shifted - trial : shifted;
			root <= {src_root[ROOT_BITS-2:0], fits};
		end
	end

	assign sqrt_out = root;

	done_after_start: assert property (@(posedge clk) disable iff (reset)
		sqrt_done |-> $past(sqrt_start, ROOT_BITS));

endmodule

// ==== hw/arc_step_select.sv ====
`timescale 1ns/1ps
`include "plot_params.svh"

module arc_step_select (
	input plot_pkg::pos_t rel_x,
	input plot_pkg::pos_t rel_y,
	input logic cw,
	input plot_pkg::r2_t r2,
	output plot_pkg::step_dir_t next_dir
);

	localparam int EXT_BITS = `PLOT_POS_BITS + 1;

	typedef logic signed [EXT_BITS-1:0] ext_t;

	function automatic plot_pkg::r2_t dist2(ext_t a, ext_t b);
		logic signed [`PLOT_R2_BITS-1:0] wa;
		logic signed [`PLOT_R2_BITS-1:0] wb;
		wa = a;
		wb = b;
		return $unsigned(wa * wa + wb * wb);
	endfunction

	function automatic plot_pkg::r2_t abs_diff(plot_pkg::r2_t a, plot_pkg::r2_t b);
		return (a >= b) ? a - b : b - a;
	endfunction

	plot_pkg::quadrant_t quad;
	logic x_up;
	logic y_up;
	ext_t ext_x;
	ext_t ext_y;
	ext_t cand_x;
	ext_t cand_y;
	plot_pkg::r2_t err_x;
	plot_pkg::r2_t err_y;
	plot_pkg::r2_t err_d;

	always_comb begin
		if (rel_x > 0 && rel_y >= 0)
			quad = plot_pkg::Q1;
		else if (rel_x <= 0 && rel_y > 0)
			quad = plot_pkg::Q2;
		else if (rel_x < 0 && rel_y <= 0)
			quad = plot_pkg::Q3;
		else
			quad = plot_pkg::Q4; // Also the origin, which is caught below
	end

	always_comb begin
		// Tangent signs for counter-clockwise travel, flipped for clockwise
		x_up = (quad == plot_pkg::Q3 || quad == plot_pkg::Q4) ^ cw;
		y_up = (quad == plot_pkg::Q1 || quad == plot_pkg::Q4) ^ cw;

		ext_x = ext_t'(rel_x);
		ext_y = ext_t'(rel_y);
		cand_x = ext_x + (x_up ? ext_t'(1) : '1);
		cand_y = ext_y + (y_up ? ext_t'(1) : '1);

		err_x = abs_diff(dist2(cand_x, ext_y), r2);
		err_y = abs_diff(dist2(ext_x, cand_y), r2);
		err_d = abs_diff(dist2(cand_x, cand_y), r2);
	end

	always_comb begin
		if (rel_x == 0 && rel_y == 0)
			next_dir = plot_pkg::E;
		else if (err_d <= err_x && err_d <= err_y) begin
			if (x_up)
				next_dir = y_up ? plot_pkg::NE : plot_pkg::SE;
			else
				next_dir = y_up ? plot_pkg::NW : plot_pkg::SW;
		end else if (err_x <= err_y)
			next_dir = x_up ? plot_pkg::E : plot_pkg::W;
		else
			next_dir = y_up ? plot_pkg::N : plot_pkg::S;
	end

endmodule

// ==== hw/arc_handler.sv ====
`timescale 1ns/1ps
`include "plot_params.svh"

module arc_handler (
	input logic clk,
	input logic reset,
	input logic arc_start,
	input logic arc_cw,
	input plot_pkg::pos_t center_x,
	input plot_pkg::pos_t center_y,
	input plot_pkg::pos_t end_x,
	input plot_pkg::pos_t end_y,
	input plot_pkg::pos_t pos_x,
	input plot_pkg::pos_t pos_y,
	input logic sqrt_done,
	input plot_pkg::root_t sqrt_out,
	input plot_pkg::step_dir_t next_dir,
	output logic sqrt_start,
	output plot_pkg::r2_t sqrt_in,
	output plot_pkg::pos_t rel_x,
	output plot_pkg::pos_t rel_y,
	output logic cw,
	output plot_pkg::r2_t r2,
	output logic step,
	output plot_pkg::step_dir_t step_dir,
	output logic arc_done,
	output logic arc_overrun
);

	localparam int CAP_BITS = `PLOT_R_BITS + $clog2(`PLOT_CAP_FACTOR) + 1;
	localparam logic [CAP_BITS-1:0] CAP_FACTOR = CAP_BITS'(`PLOT_CAP_FACTOR);

	plot_pkg::arc_state_t state;
	plot_pkg::pos_t cen_x;
	plot_pkg::pos_t cen_y;
	plot_pkg::pos_t tgt_x;
	plot_pkg::pos_t tgt_y;
	logic [CAP_BITS-1:0] cap;
	logic [CAP_BITS-1:0] count;
	logic [CAP_BITS-1:0] count_next;
	logic overrun;

	plot_pkg::pos_t start_dx;
	plot_pkg::pos_t start_dy;
	logic signed [`PLOT_R2_BITS-1:0] wide_dx;
	logic signed [`PLOT_R2_BITS-1:0] wide_dy;
	plot_pkg::r2_t start_r2;
	plot_pkg::pos_t next_x;
	plot_pkg::pos_t next_y;
	logic at_end;
	logic cap_hit;

	always_comb begin
		start_dx = pos_x - center_x; // Start radius uses the center as it arrives
		start_dy = pos_y - center_y;
		wide_dx = start_dx;
		wide_dy = start_dy;
		start_r2 = $unsigned(wide_dx * wide_dx + wide_dy * wide_dy);

		rel_x = pos_x - cen_x;
		rel_y = pos_y - cen_y;

		// End test looks at the position this step will produce
		next_x = pos_x + plot_pkg::pos_t'(plot_pkg::dir_dx(next_dir));
		next_y = pos_y + plot_pkg::pos_t'(plot_pkg::dir_dy(next_dir));
		at_end = (next_x == tgt_x) && (next_y == tgt_y);
		count_next = count + 1'b1;
		cap_hit = count_next == cap;
	end

	assign sqrt_in = r2;
	assign step = state == plot_pkg::ARC_STEP;
	assign step_dir = next_dir;
	assign arc_done = state == plot_pkg::ARC_END;
	assign arc_overrun = arc_done && overrun;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= plot_pkg::ARC_IDLE;
			sqrt_start <= 1'b0;
			count <= '0;
			overrun <= 1'b0;
		end else begin
			sqrt_start <= 1'b0;
			case (state)
				plot_pkg::ARC_IDLE: begin
					if (arc_start) begin
						state <= plot_pkg::ARC_SQRT;
						sqrt_start <= 1'b1;
					end
				end
				plot_pkg::ARC_SQRT: begin
					if (sqrt_done) begin
						state <= plot_pkg::ARC_STEP;
						count <= '0;
						overrun <= 1'b0;
					end
				end
				plot_pkg::ARC_STEP: begin
					count <= count_next;
					if (at_end || cap_hit) begin
						state <= plot_pkg::ARC_END;
						overrun <= !at_end; // Landing on the end point wins over the cap
					end
				end
				plot_pkg::ARC_END: state <= plot_pkg::ARC_IDLE;
				default: state <= plot_pkg::ARC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == plot_pkg::ARC_IDLE && arc_start) begin
			cen_x <= center_x;
			cen_y <= center_y;
			tgt_x <= end_x;
			tgt_y <= end_y;
			cw <= arc_cw;
			r2 <= start_r2;
		end
		if (sqrt_done)
			cap <= CAP_FACTOR * CAP_BITS'(sqrt_out) + CAP_FACTOR;
	end

	// Steps form one unbroken run that begins right after the root
	step_run: assert property (@(posedge clk) disable iff (reset)
		step |-> $past(sqrt_done) || $past(step));

	done_pulse: assert property (@(posedge clk) disable iff (reset)
		arc_done |=> !arc_done);

endmodule

// ==== hw/op_dispatch.sv ====
`timescale 1ns/1ps

module op_dispatch (
	input logic clk,
	input logic reset,
	input logic op_valid,
	input plot_pkg::opcode_t op_code,
	input plot_pkg::pos_t op_x,
	input plot_pkg::pos_t op_y,
	input plot_pkg::pos_t op_i,
	input plot_pkg::pos_t op_j,
	input logic arc_step,
	input plot_pkg::step_dir_t arc_step_dir,
	input logic arc_done,
	input logic arc_overrun_in,
	output logic rdy,
	output logic op_dropped,
	output logic op_illegal,
	output logic arc_start,
	output logic arc_cw,
	output plot_pkg::pos_t center_x,
	output plot_pkg::pos_t center_y,
	output plot_pkg::pos_t end_x,
	output plot_pkg::pos_t end_y,
	output plot_pkg::pos_t pos_x,
	output plot_pkg::pos_t pos_y,
	output logic pen_down,
	output logic step,
	output plot_pkg::step_dir_t step_dir,
	output logic done,
	output logic arc_overrun
);

	logic busy;
	logic accept;
	logic legal;

	assign accept = op_valid && !busy;
	assign rdy = !busy;

	always_comb begin
		case (op_code)
			plot_pkg::OP_MOVE,
			plot_pkg::OP_PEN_UP,
			plot_pkg::OP_PEN_DOWN,
			plot_pkg::OP_ARC_CW,
			plot_pkg::OP_ARC_CCW: legal = 1'b1;
			default: legal = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			op_dropped <= 1'b0;
			op_illegal <= 1'b0;
			arc_start <= 1'b0;
			pos_x <= '0;
			pos_y <= '0;
			pen_down <= 1'b0;
			step <= 1'b0;
			done <= 1'b0;
			arc_overrun <= 1'b0;
		end else begin
			op_dropped <= op_valid && busy;
			op_illegal <= accept && !legal;
			arc_start <= 1'b0;
			step <= arc_step;
			done <= arc_done;
			arc_overrun <= arc_done && arc_overrun_in;
			if (done)
				busy <= 1'b0; // Ready again in the cycle after done
			if (arc_step) begin
				pos_x <= pos_x + plot_pkg::pos_t'(plot_pkg::dir_dx(arc_step_dir));
				pos_y <= pos_y + plot_pkg::pos_t'(plot_pkg::dir_dy(arc_step_dir));
			end
			if (accept && legal) begin
				busy <= 1'b1;
				case (op_code)
					plot_pkg::OP_MOVE: begin
						pos_x <= op_x; // A move is a jump with the pen raised
						pos_y <= op_y;
						pen_down <= 1'b0;
						done <= 1'b1;
					end
					plot_pkg::OP_PEN_UP: begin
						pen_down <= 1'b0;
						done <= 1'b1;
					end
					plot_pkg::OP_PEN_DOWN: begin
						pen_down <= 1'b1;
						done <= 1'b1;
					end
					default: begin
						arc_start <= 1'b1;
						pen_down <= 1'b1;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		step_dir <= arc_step_dir;
		if (accept) begin
			center_x <= pos_x + op_i;
			center_y <= pos_y + op_j;
			end_x <= op_x;
			end_y <= op_y;
			arc_cw <= op_code == plot_pkg::OP_ARC_CW;
		end
	end

	step_while_busy: assert property (@(posedge clk) disable iff (reset)
		arc_step |-> busy);

endmodule

// ==== hw/plot_core.sv ====
`timescale 1ns/1ps

module plot_core (
	input logic clk,
	input logic reset,
	input logic op_valid,
	input plot_pkg::opcode_t op_code,
	input plot_pkg::pos_t op_x,
	input plot_pkg::pos_t op_y,
	input plot_pkg::pos_t op_i,
	input plot_pkg::pos_t op_j,
	output logic rdy,
	output logic op_dropped,
	output logic op_illegal,
	output logic step,
	output plot_pkg::step_dir_t step_dir,
	output plot_pkg::pos_t pos_x,
	output plot_pkg::pos_t pos_y,
	output logic pen_down,
	output logic done,
	output logic arc_overrun
);

	logic arc_start;
	logic arc_cw;
	plot_pkg::pos_t center_x;
	plot_pkg::pos_t center_y;
	plot_pkg::pos_t end_x;
	plot_pkg::pos_t end_y;
	logic arc_step;
	plot_pkg::step_dir_t arc_step_dir;
	logic arc_done;
	logic arc_hit_cap;
	logic sqrt_start;
	plot_pkg::r2_t sqrt_in;
	logic sqrt_done;
	plot_pkg::root_t sqrt_out;
	plot_pkg::pos_t rel_x;
	plot_pkg::pos_t rel_y;
	logic sel_cw;
	plot_pkg::r2_t r2;
	plot_pkg::step_dir_t next_dir;

	op_dispatch u_dispatch (
		.clk(clk),
		.reset(reset),
		.op_valid(op_valid),
		.op_code(op_code),
		.op_x(op_x),
		.op_y(op_y),
		.op_i(op_i),
		.op_j(op_j),
		.arc_step(arc_step),
		.arc_step_dir(arc_step_dir),
		.arc_done(arc_done),
		.arc_overrun_in(arc_hit_cap),
		.rdy(rdy),
		.op_dropped(op_dropped),
		.op_illegal(op_illegal),
		.arc_start(arc_start),
		.arc_cw(arc_cw),
		.center_x(center_x),
		.center_y(center_y),
		.end_x(end_x),
		.end_y(end_y),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.pen_down(pen_down),
		.step(step),
		.step_dir(step_dir),
		.done(done),
		.arc_overrun(arc_overrun)
	);

	arc_handler u_arc (
		.clk(clk),
		.reset(reset),
		.arc_start(arc_start),
		.arc_cw(arc_cw),
		.center_x(center_x),
		.center_y(center_y),
		.end_x(end_x),
		.end_y(end_y),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.sqrt_done(sqrt_done),
		.sqrt_out(sqrt_out),
		.next_dir(next_dir),
		.sqrt_start(sqrt_start),
		.sqrt_in(sqrt_in),
		.rel_x(rel_x),
		.rel_y(rel_y),
		.cw(sel_cw),
		.r2(r2),
		.step(arc_step),
		.step_dir(arc_step_dir),
		.arc_done(arc_done),
		.arc_overrun(arc_hit_cap)
	);

	arc_step_select u_select (
		.rel_x(rel_x),
		.rel_y(rel_y),
		.cw(sel_cw),
		.r2(r2),
		.next_dir(next_dir)
	);

	int_sqrt u_sqrt (
		.clk(clk),
		.reset(reset),
		.sqrt_start(sqrt_start),
		.sqrt_in(sqrt_in),
		.sqrt_done(sqrt_done),
		.sqrt_out(sqrt_out)
	);

endmodule

// ==== bench/plot_model.svh ====
`ifndef PLOT_MODEL_SVH
`define PLOT_MODEL_SVH

function automatic int quad_of(input int x, input int y);
	if (x > 0 && y >= 0)
		return 1;
	else if (x <= 0 && y > 0)
		return 2;
	else if (x < 0 && y <= 0)
		return 3;
	return 4; // Covers x >= 0 with y < 0
endfunction

function automatic int dist_err(input int x, input int y, input int r2);
	int d;
	d = x * x + y * y - r2;
	return (d < 0) ? -d : d;
endfunction

function automatic int dir_code(input int dx, input int dy);
	plot_pkg::step_dir_t d;
	if (dy == 0)
		d = (dx > 0) ? plot_pkg::E : plot_pkg::W;
	else if (dx == 0)
		d = (dy > 0) ? plot_pkg::N : plot_pkg::S;
	else if (dx > 0)
		d = (dy > 0) ? plot_pkg::NE : plot_pkg::SE;
	else
		d = (dy > 0) ? plot_pkg::NW : plot_pkg::SW;
	return int'(d);
endfunction

// One walk step from a point relative to the center, returns the direction code
function automatic int choose_step(input int x, input int y, input bit cw, input int r2,
		output int dx, output int dy);
	int q;
	int sx;
	int sy;
	int ex;
	int ey;
	int ed;
	q = quad_of(x, y);
	sx = (q == 3 || q == 4) ? 1 : -1; // Counter-clockwise tangent
	sy = (q == 1 || q == 4) ? 1 : -1;
	if (cw) begin
		sx = -sx;
		sy = -sy;
	end
	ex = dist_err(x + sx, y, r2);
	ey = dist_err(x, y + sy, r2);
	ed = dist_err(x + sx, y + sy, r2);
	if (x == 0 && y == 0) begin
		dx = 1;
		dy = 0;
	end else if (ed <= ex && ed <= ey) begin
		dx = sx;
		dy = sy;
	end else if (ex <= ey) begin
		dx = sx;
		dy = 0;
	end else begin
		dx = 0;
		dy = sy;
	end
	return dir_code(dx, dy);
endfunction

function automatic int isqrt(input int v);
	int r;
	r = 0;
	while ((r + 1) * (r + 1) <= v)
		r++;
	return r;
endfunction

function automatic int cap_of(input int r2);
	return `PLOT_CAP_FACTOR * isqrt(r2) + `PLOT_CAP_FACTOR;
endfunction

function automatic void walk_to(input int x, input int y, input bit cw, input int r2,
		input int k, output int ex, output int ey);
	int n;
	int dx;
	int dy;
	ex = x;
	ey = y;
	for (n = 0; n < k; n++) begin
		void'(choose_step(ex, ey, cw, r2, dx, dy));
		ex += dx;
		ey += dy;
	end
endfunction

// Steps until the end point or the cap, landing on the end point wins over the cap
function automatic int lap_steps(input int x, input int y, input bit cw, input int r2,
		input int ex, input int ey, input int cap, output bit over);
	int n;
	int px;
	int py;
	int dx;
	int dy;
	px = x;
	py = y;
	for (n = 1; n <= cap; n++) begin
		void'(choose_step(px, py, cw, r2, dx, dy));
		px += dx;
		py += dy;
		if (px == ex && py == ey) begin
			over = 1'b0;
			return n;
		end
	end
	over = 1'b1;
	return cap;
endfunction

`endif

// ==== bench/plot_tb.sv ====
`timescale 1ns/1ps
`include "plot_params.svh"

module plot_tb;

	localparam int N_RANDOM = 12;
	localparam int N_CIRCLE = 3;
	localparam int N_OVERRUN = 2;
	localparam int MAX_R = 200;
	localparam int N_ARCS = N_RANDOM + N_CIRCLE + N_OVERRUN;
	// A full cap of steps behind the root plus the handshake cycles
	localparam int ARC_CYCLES = `PLOT_CAP_FACTOR * (MAX_R + 1) + `PLOT_R_BITS + 16;
	localparam int CYCLE_LIMIT = N_ARCS * ARC_CYCLES + (N_ARCS + 8) * 8 + 100;

	logic clk = 1'b0;
	logic reset;
	logic op_valid;
	plot_pkg::opcode_t op_code;
	plot_pkg::pos_t op_x;
	plot_pkg::pos_t op_y;
	plot_pkg::pos_t op_i;
	plot_pkg::pos_t op_j;
	logic rdy;
	logic op_dropped;
	logic op_illegal;
	logic step;
	plot_pkg::step_dir_t step_dir;
	plot_pkg::pos_t pos_x;
	plot_pkg::pos_t pos_y;
	logic pen_down;
	logic done;
	logic arc_overrun;

	int cycles = 0;
	int cur_x = 0; // Model position of the pen
	int cur_y = 0;

	`include "plot_model.svh"

	plot_core UUT (.*);

	always #50 clk = ~clk;

	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic signed [31:0] got,
			input logic signed [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with tests still running", cycles);
			stop_run();
		end
	end

	function automatic int rand_between(input int lo, input int hi);
		return lo + int'($urandom_range(hi - lo));
	endfunction

	task automatic pick_offset(input int max_r, output int ci, output int cj);
		int r;
		do begin
			ci = rand_between(-max_r, max_r);
			cj = rand_between(-max_r, max_r);
			r = isqrt(ci * ci + cj * cj);
		end while (r < 3 || r > max_r);
	endtask

	task automatic send_op(input plot_pkg::opcode_t code, input int x, input int y,
			input int i, input int j);
		@(posedge clk);
		op_valid <= 1'b1;
		op_code <= code;
		op_x <= plot_pkg::pos_t'(x);
		op_y <= plot_pkg::pos_t'(y);
		op_i <= plot_pkg::pos_t'(i);
		op_j <= plot_pkg::pos_t'(j);
		@(posedge clk);
		op_valid <= 1'b0;
	endtask

	task automatic expect_idle();
		@(negedge clk);
		check_value("rdy", rdy, 1);
		check_value("done", done, 0);
		check_value("step", step, 0);
	endtask

	task automatic move_to(input int x, input int y);
		send_op(plot_pkg::OP_MOVE, x, y, 0, 0);
		@(negedge clk);
		check_value("done", done, 1); // One cycle after the strobe
		check_value("pos_x", pos_x, x);
		check_value("pos_y", pos_y, y);
		check_value("pen_down", pen_down, 0);
		check_value("rdy", rdy, 0);
		cur_x = x;
		cur_y = y;
		expect_idle();
	endtask

	task automatic set_pen(input bit down);
		plot_pkg::opcode_t code;
		code = down ? plot_pkg::OP_PEN_DOWN : plot_pkg::OP_PEN_UP;
		send_op(code, cur_x, cur_y, 0, 0);
		@(negedge clk);
		check_value("done", done, 1);
		check_value("pen_down", pen_down, down);
		check_value("step", step, 0);
		check_value("pos_x", pos_x, cur_x);
		check_value("pos_y", pos_y, cur_y);
		expect_idle();
	endtask

	task automatic send_illegal();
		send_op(plot_pkg::opcode_t'(3'd6), 5, 5, 0, 0);
		@(negedge clk);
		check_value("op_illegal", op_illegal, 1);
		check_value("done", done, 0);
		check_value("rdy", rdy, 1);
		@(negedge clk);
		check_value("op_illegal", op_illegal, 0);
		check_value("done", done, 0);
		check_value("pos_x", pos_x, cur_x);
		check_value("pos_y", pos_y, cur_y);
	endtask

	// Runs one arc and follows it step by step, optionally strobing an op while busy
	task automatic run_arc(input bit cw, input int ci, input int cj, input int end_x,
			input int end_y, input bit drop);
		plot_pkg::opcode_t code;
		int cx;
		int cy;
		int r2;
		int cap;
		int exp_n;
		int n;
		int dx;
		int dy;
		int dir;
		int cyc;
		int drops;
		bit exp_over;
		bit finished;
		cx = cur_x + ci;
		cy = cur_y + cj;
		r2 = ci * ci + cj * cj;
		cap = cap_of(r2);
		exp_n = lap_steps(cur_x - cx, cur_y - cy, cw, r2, end_x - cx, end_y - cy, cap, exp_over);
		if (cw)
			code = plot_pkg::OP_ARC_CW;
		else
			code = plot_pkg::OP_ARC_CCW;
		send_op(code, end_x, end_y, ci, cj);
		n = 0;
		cyc = 0;
		drops = 0;
		finished = 1'b0;
		while (!finished) begin
			@(negedge clk);
			check_value("rdy", rdy, 0);
			check_value("pen_down", pen_down, 1);
			if (op_dropped)
				drops++;
			if (step) begin
				if (n >= exp_n) begin
					$display("Arc made more steps than the model walk of %0d", exp_n);
					stop_run();
				end
				dir = choose_step(cur_x - cx, cur_y - cy, cw, r2, dx, dy);
				cur_x += dx;
				cur_y += dy;
				n++;
				check_value("step_dir", step_dir, dir);
				check_value("pos_x", pos_x, cur_x);
				check_value("pos_y", pos_y, cur_y);
			end
			if (done) begin
				check_value("step count", n, exp_n);
				check_value("arc_overrun", arc_overrun, exp_over);
				finished = 1'b1;
			end else begin
				check_value("arc_overrun", arc_overrun, 0);
				if (cyc > cap + `PLOT_R_BITS + 8) begin
					$display("Arc gave no done within %0d cycles after %0d steps", cyc, n);
					stop_run();
				end
				@(posedge clk);
				op_valid <= drop && cyc == 2; // Lands while the root is running
				op_code <= plot_pkg::OP_MOVE;
				cyc++;
			end
		end
		check_value("op_dropped count", drops, drop);
		expect_idle();
	endtask

	initial begin
		int ci;
		int cj;
		int r2;
		int k;
		int ex;
		int ey;
		int tries;
		bit cw;
		bit over;
		void'($urandom(4454));
		reset <= 1'b1;
		op_valid <= 1'b0;
		op_code <= plot_pkg::OP_MOVE;
		op_x <= '0;
		op_y <= '0;
		op_i <= '0;
		op_j <= '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("rdy", rdy, 1);
		check_value("step", step, 0);
		check_value("done", done, 0);
		check_value("arc_overrun", arc_overrun, 0);
		check_value("op_dropped", op_dropped, 0);
		check_value("op_illegal", op_illegal, 0);
		check_value("pen_down", pen_down, 0);
		check_value("pos_x", pos_x, 0);
		check_value("pos_y", pos_y, 0);

		move_to(300, -200);
		set_pen(1'b1);
		set_pen(1'b0);
		send_illegal();

		for (int t = 0; t < N_RANDOM; t++) begin
			move_to(rand_between(-800, 800), rand_between(-800, 800));
			pick_offset(MAX_R, ci, cj);
			r2 = ci * ci + cj * cj;
			cw = $urandom_range(1) == 1;
			// End point k steps down the walk, first reached at step k
			do begin
				k = rand_between(1, cap_of(r2) / 2 - 1);
				walk_to(-ci, -cj, cw, r2, k, ex, ey);
			end while (lap_steps(-ci, -cj, cw, r2, ex, ey, cap_of(r2), over) != k);
			run_arc(cw, ci, cj, cur_x + ci + ex, cur_y + cj + ey, t % 3 == 0);
		end

		for (int t = 0; t < N_CIRCLE; t++) begin
			move_to(rand_between(-800, 800), rand_between(-800, 800));
			tries = 0;
			do begin
				tries++;
				if (tries > 1000) begin
					$display("No closed lap found for a full circle arc");
					stop_run();
				end
				pick_offset(40, ci, cj);
				r2 = ci * ci + cj * cj;
				cw = $urandom_range(1) == 1;
				void'(lap_steps(-ci, -cj, cw, r2, -ci, -cj, cap_of(r2), over));
			end while (over);
			run_arc(cw, ci, cj, cur_x, cur_y, 1'b0);
		end

		for (int t = 0; t < N_OVERRUN; t++) begin
			move_to(rand_between(-800, 800), rand_between(-800, 800));
			pick_offset(60, ci, cj);
			r2 = ci * ci + cj * cj;
			cw = $urandom_range(1) == 1;
			// The center is never on the walk so the cap ends the arc
			k = lap_steps(-ci, -cj, cw, r2, 0, 0, cap_of(r2), over);
			if (!over || k != cap_of(r2)) begin
				$display("Overrun arc ends on the model walk after %0d steps", k);
				stop_run();
			end
			run_arc(cw, ci, cj, cur_x + ci, cur_y + cj, 1'b0);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+hw
+incdir+bench
hw/plot_pkg.sv
hw/int_sqrt.sv
hw/arc_step_select.sv
hw/arc_handler.sv
hw/op_dispatch.sv
hw/plot_core.sv
bench/plot_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the plotter core testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module plot_tb -f build.f -o plot_sim \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/plot_sim 2>&1 | tee sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && exit 0 || { echo "No pass result in log"; exit 1; }
